/* Bender.yml */
package:
  name: serial_bus_slave

sources:
  - include_dirs:
      - include
    files:
      - src/sbus_frame_pkg.sv
      - src/sbus_slave_pkg.sv
      - src/serial_shift_in.sv
      - src/frame_decoder.sv
      - src/transfer_engine.sv
      - src/slave_memory.sv
      - src/read_serializer.sv
      - src/serial_bus_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_serial_bus_slave.sv

/* all.f */
+incdir+include
src/sbus_frame_pkg.sv
src/sbus_slave_pkg.sv
src/serial_shift_in.sv
src/frame_decoder.sv
src/transfer_engine.sv
src/slave_memory.sv
src/read_serializer.sv
src/serial_bus_slave.sv
sim/tb_serial_bus_slave.sv

/* include/sbus_consts.svh */
// serial bus slave constants

`ifndef SBUS_CONSTS_SVH
`define SBUS_CONSTS_SVH

// data word carried on wD and rD
`define SBUS_DATA_WIDTH 32

// word address, sized to the RAM depth
`define SBUS_ADDR_WIDTH 8
`define SBUS_MEM_DEPTH  256

// slave select field of the header
`define SBUS_ID_WIDTH 2

// start code that opens every frame
`define SBUS_START_CODE 3'b111

// start + id + r/w + burst + address
`define SBUS_HDR_BITS 15

`endif

/* sim/tb_serial_bus_slave.sv */
// serial bus slave testbench

`default_nettype none

`include "sbus_consts.svh"

module tb_serial_bus_slave;

    localparam sbus_frame_pkg::slave_id_t DUT_ID = 2'd1;
    localparam int GAP_MAX   = 3;
    localparam int READ_WAIT = 200;
    // 11 frames, 16 words moved, 4 of them with valid gaps, one silent read window
    localparam int RUN_CYCLES = 2 + 11 * (`SBUS_HDR_BITS + 8) + 16 * 32
                              + 4 * 32 * GAP_MAX + 40;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES * 6 / 5;

    logic clk = 1'b0;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    integer seed = 32'h9fd18d33;
    int     cycle = 0;
    int     value_errors = 0;
    int     protocol_errors = 0;

    // reference memory and the words the reads should return
    sbus_frame_pkg::word_t model [sbus_frame_pkg::addr_t];
    sbus_frame_pkg::word_t exp_mem [0:31];
    int exp_count = 0;
    int frame_first = 0;
    int hdr_end = 0;

    // receive side
    logic [31:0] rx_shift;
    logic [4:0]  rx_cnt;
    int          rx_words;
    logic        ready_q;
    logic [3:0]  gap_cnt;

    always #5 clk = ~clk;

    serial_bus_slave #(
        .SLAVE_ID (DUT_ID)
    ) dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // collect rD bits while ready is high
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rx_shift <= '0;
            rx_cnt   <= '0;
            rx_words <= 0;
            ready_q  <= 1'b0;
            gap_cnt  <= '0;
        end else begin
            ready_q <= ready;
            if (ready) begin
                gap_cnt  <= '0;
                rx_shift <= {rx_shift[30:0], rD};
                rx_cnt   <= rx_cnt + 1'b1;
                if (rx_cnt == 5'd31) begin
                    rx_words <= rx_words + 1;
                end
            end else if (gap_cnt != 4'hf) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    a_word_value: assert property (@(posedge clk) disable iff (!rstN)
        ready && rx_cnt == 5'd31 |-> {rx_shift[30:0], rD} == exp_mem[rx_words])
        else begin
            value_errors++;
            $display("Fail %0t: read word %0d is %h, expected %h", $time,
                     $sampled(rx_words), $sampled({rx_shift[30:0], rD}),
                     $sampled(exp_mem[rx_words]));
        end

    a_ready_expected: assert property (@(posedge clk) disable iff (!rstN)
        ready |-> rx_words < exp_count)
        else begin
            protocol_errors++;
            $display("ready went high at %0t with no read word pending", $time);
        end

    a_rd_quiet: assert property (@(posedge clk) disable iff (!rstN)
        !ready |-> !rD)
        else begin
            protocol_errors++;
            $display("rD was high without ready at %0t", $time);
        end

    a_whole_word: assert property (@(posedge clk) disable iff (!rstN)
        !ready && ready_q |-> rx_cnt == 5'd0)
        else begin
            protocol_errors++;
            $display("ready dropped in the middle of a word at %0t", $time);
        end

    // first bit of a frame lands 3 cycles after the last header bit
    a_first_latency: assert property (@(posedge clk) disable iff (!rstN)
        ready && !ready_q && rx_words == frame_first |-> cycle == hdr_end + 3)
        else begin
            protocol_errors++;
            $display("first read bit did not come 3 cycles after the header at %0t", $time);
        end

    a_burst_gap: assert property (@(posedge clk) disable iff (!rstN)
        ready && !ready_q && rx_words != frame_first |-> gap_cnt == 4'd2)
        else begin
            protocol_errors++;
            $display("burst read gap was not 2 cycles at %0t", $time);
        end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_header(input sbus_frame_pkg::slave_id_t id, input logic is_write,
                               input logic burst, input sbus_frame_pkg::addr_t addr);
        sbus_frame_pkg::frame_header_t hdr;
        logic [`SBUS_HDR_BITS-1:0]     bits;
        hdr.start    = `SBUS_START_CODE;
        hdr.slave_id = id;
        hdr.is_write = is_write;
        hdr.burst    = burst;
        hdr.addr     = addr;
        bits         = hdr;
        for (int i = `SBUS_HDR_BITS - 1; i >= 0; i--) begin
            control = bits[i];
            @(posedge clk);
            #1;
        end
        // the last bit was sampled on the edge just passed
        hdr_end = cycle;
        control = 1'b0;
    endtask

    task automatic write_frame(input sbus_frame_pkg::slave_id_t id, input logic burst,
                               input sbus_frame_pkg::addr_t addr, input int n,
                               input bit gaps);
        sbus_frame_pkg::word_t data;
        int                    gap;
        send_header(id, 1'b1, burst, addr);
        // engine enters collection one cycle after accept
        idle(1);
        for (int w = 0; w < n; w++) begin
            data = $random(seed);
            for (int b = 31; b >= 0; b--) begin
                gap = gaps ? ($unsigned($random(seed)) % (GAP_MAX + 1)) : 0;
                repeat (gap) begin
                    valid = 1'b0;
                    idle(1);
                end
                valid = 1'b1;
                wD    = data[b];
                last  = burst && (w == n - 1);
                idle(1);
            end
            if (id == DUT_ID) begin
                model[sbus_frame_pkg::addr_t'(addr + w)] = data;
            end
        end
        valid = 1'b0;
        wD    = 1'b0;
        last  = 1'b0;
        idle(4);
    endtask

    task automatic read_frame(input sbus_frame_pkg::slave_id_t id, input logic burst,
                              input sbus_frame_pkg::addr_t addr, input int n);
        int waited;
        if (id == DUT_ID) begin
            frame_first = exp_count;
            for (int w = 0; w < n; w++) begin
                exp_mem[exp_count + w] = model[sbus_frame_pkg::addr_t'(addr + w)];
            end
            exp_count = exp_count + n;
        end
        send_header(id, 1'b0, burst, addr);
        waited = 0;
        while (rx_words != exp_count && waited < READ_WAIT) begin
            // mark the final burst word while it shifts out
            if (burst && ready && rx_words == exp_count - 1) begin
                last = 1'b1;
            end
            idle(1);
            waited++;
        end
        last = 1'b0;
        if (rx_words != exp_count) begin
            protocol_errors++;
            $display("read at address %h got no data within %0d cycles", addr, READ_WAIT);
        end
        // unaddressed reads get a full word window to show any stray ready
        idle(id == DUT_ID ? 4 : 40);
    endtask

    initial begin
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        idle(3);

        write_frame(DUT_ID, 1'b0, 8'h12, 1, 1'b0);
        read_frame(DUT_ID, 1'b0, 8'h12, 1);

        write_frame(DUT_ID, 1'b1, 8'h40, 4, 1'b1);
        for (int i = 0; i < 4; i++) begin
            read_frame(DUT_ID, 1'b0, sbus_frame_pkg::addr_t'(8'h40 + i), 1);
        end

        read_frame(DUT_ID, 1'b1, 8'h40, 4);

        // frames for another slave
        write_frame(2'd2, 1'b0, 8'h12, 1, 1'b0);
        read_frame(2'd2, 1'b0, 8'h12, 1);
        read_frame(DUT_ID, 1'b0, 8'h12, 1);
        idle(4);

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/frame_decoder.sv */
// header decoder for the control line

`default_nettype none

`include "sbus_consts.svh"

module frame_decoder #(
    parameter sbus_frame_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   control,
    input  wire logic                   busy,
    output sbus_frame_pkg::frame_header_t header,
    output logic                        hdr_accept
);
    logic                          collecting;
    logic                          start_frame;
    logic                          hdr_shift;
    logic                          hdr_full;
    logic                          last_bit;
    logic [`SBUS_HDR_BITS-1:0]     hdr_bits;
    sbus_frame_pkg::frame_header_t next_header;

    assign start_frame = !collecting && !busy && control;
    assign hdr_shift   = start_frame || collecting;
    assign hdr_bits    = header;

    // the leading start bit is a one shifted into a cleared register,
    // so it reaches the second bit from the top just before the last bit
    assign last_bit    = collecting && hdr_bits[`SBUS_HDR_BITS-2];
    assign next_header = {hdr_bits[`SBUS_HDR_BITS-2:0], control};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            collecting <= 1'b0;
            hdr_accept <= 1'b0;
        end else begin
            // only frames for this slave reach the engine
            hdr_accept <= last_bit
                       && (next_header.start == `SBUS_START_CODE)
                       && (next_header.slave_id == SLAVE_ID);
            if (start_frame) begin
                collecting <= 1'b1;
            end else if (last_bit) begin
                collecting <= 1'b0;
            end
        end
    end

    serial_shift_in #(
        .payload_t (sbus_frame_pkg::frame_header_t)
    ) u_hdr_shift (
        .clk      (clk),
        .rstN     (rstN),
        .clear    (start_frame),
        .shift_en (hdr_shift),
        .bit_in   (control),
        .payload  (header),
        .full     (hdr_full)
    );

    // accept lands with a complete header and an idle engine
    a_accept_full: assert property (@(posedge clk) disable iff (!rstN)
        hdr_accept |-> hdr_full && !busy);

endmodule

`default_nettype wire

/* src/read_serializer.sv */
// read word serializer for rD

`default_nettype none

module read_serializer (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  load,
    input  wire sbus_frame_pkg::word_t word,
    output logic                       rD,
    output logic                       ready,
    output logic                       done
);
    localparam int WIDTH = $bits(sbus_frame_pkg::word_t);
    localparam int CNT_W = $clog2(WIDTH);

    logic [WIDTH-1:0] shreg;
    logic [CNT_W-1:0] bits_left;

    // final bit is on rD
    assign done = ready && (bits_left == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ready     <= 1'b0;
            rD        <= 1'b0;
            bits_left <= '0;
        end else if (load) begin
            ready     <= 1'b1;
            rD        <= word[WIDTH-1];
            bits_left <= CNT_W'(WIDTH - 1);
        end else if (done) begin
            ready <= 1'b0;
            rD    <= 1'b0;
        end else if (ready) begin
            rD        <= shreg[WIDTH-1];
            bits_left <= bits_left - 1'b1;
        end
    end

    // remaining bits, msb next
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {word[WIDTH-2:0], 1'b0};
        end else if (ready) begin
            shreg <= {shreg[WIDTH-2:0], 1'b0};
        end
    end

    a_no_load_busy: assert property (@(posedge clk) disable iff (!rstN)
        load |-> !ready);

endmodule

`default_nettype wire

/* src/sbus_frame_pkg.sv */
// serial frame types

`default_nettype none

`include "sbus_consts.svh"

package sbus_frame_pkg;

    typedef logic [`SBUS_DATA_WIDTH-1:0] word_t;
    typedef logic [`SBUS_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`SBUS_ID_WIDTH-1:0]   slave_id_t;

    // header fields in the order they arrive on control, msb first
    typedef struct packed {
        logic [$bits(`SBUS_START_CODE)-1:0] start;
        slave_id_t                          slave_id;
        logic                               is_write;   // 1 write, 0 read
        logic                               burst;
        addr_t                              addr;
    } frame_header_t;

endpackage

`default_nettype wire

/* src/sbus_slave_pkg.sv */
// slave transfer types

`default_nettype none

package sbus_slave_pkg;

    // one access to the word RAM
    typedef struct packed {
        logic                  rd_en;
        logic                  wr_en;
        sbus_frame_pkg::addr_t addr;
        sbus_frame_pkg::word_t wdata;
    } mem_req_t;

    // transfer engine states
    typedef enum logic [1:0] {
        IDLE,
        WRITE_COLLECT,
        READ_FETCH,
        READ_SHIFT
    } engine_state_e;

endpackage

`default_nettype wire

/* src/serial_bus_slave.sv */
// serial bus slave top level

`default_nettype none

module serial_bus_slave #(
    parameter sbus_frame_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic control,
    input  wire logic wD,
    input  wire logic valid,
    input  wire logic last,
    output logic      rD,
    output logic      ready
);
    sbus_frame_pkg::frame_header_t header;
    sbus_frame_pkg::word_t         rdata;
    sbus_slave_pkg::mem_req_t      mem_req;
    logic                          hdr_accept;
    logic                          busy;
    logic                          load;
    logic                          done;

    frame_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) u_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .busy       (busy),
        .header     (header),
        .hdr_accept (hdr_accept)
    );

    transfer_engine u_engine (
        .clk        (clk),
        .rstN       (rstN),
        .header     (header),
        .hdr_accept (hdr_accept),
        .wD         (wD),
        .valid      (valid),
        .last       (last),
        .done       (done),
        .mem_req    (mem_req),
        .load       (load),
        .busy       (busy)
    );

    slave_memory u_memory (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    read_serializer u_serializer (
        .clk   (clk),
        .rstN  (rstN),
        .load  (load),
        .word  (rdata),
        .rD    (rD),
        .ready (ready),
        .done  (done)
    );

endmodule

`default_nettype wire

/* src/serial_shift_in.sv */
// serial to parallel shifter

`default_nettype none

module serial_shift_in #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic clear,
    input  wire logic shift_en,
    input  wire logic bit_in,
    output payload_t  payload,
    output logic      full
);
    localparam int WIDTH = $bits(payload_t);
    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [WIDTH-1:0] shreg;
    logic [CNT_W-1:0] count;

    // bit count, a clear with a shift keeps that first bit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (clear) begin
            count <= CNT_W'(shift_en);
        end else if (shift_en) begin
            count <= count + 1'b1;
        end
    end

    // msb arrives first and ends up on top
    always_ff @(posedge clk) begin
        if (clear) begin
            shreg <= WIDTH'(shift_en & bit_in);
        end else if (shift_en) begin
            shreg <= {shreg[WIDTH-2:0], bit_in};
        end
    end

    assign payload = payload_t'(shreg);
    assign full    = (count == CNT_W'(WIDTH));

    a_no_overrun: assert property (@(posedge clk) disable iff (!rstN)
        shift_en && !clear |-> !full);

endmodule

`default_nettype wire

/* src/slave_memory.sv */
// slave word RAM

`default_nettype none

`include "sbus_consts.svh"

module slave_memory (
    input  wire logic                     clk,
    input  wire sbus_slave_pkg::mem_req_t mem_req,
    output sbus_frame_pkg::word_t         rdata
);
    sbus_frame_pkg::word_t mem [`SBUS_MEM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (mem_req.wr_en) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (mem_req.rd_en) begin
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

/* src/transfer_engine.sv */
// transfer state machine

`default_nettype none

module transfer_engine (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire sbus_frame_pkg::frame_header_t header,
    input  wire logic                    hdr_accept,
    input  wire logic                    wD,
    input  wire logic                    valid,
    input  wire logic                    last,
    input  wire logic                    done,
    output sbus_slave_pkg::mem_req_t     mem_req,
    output logic                         load,
    output logic                         busy
);
    sbus_slave_pkg::engine_state_e state;
    sbus_frame_pkg::addr_t         addr;
    sbus_frame_pkg::word_t         word;
    logic                          burst;
    logic                          last_seen;
    logic                          word_shift;
    logic                          word_clear;
    logic                          word_full;
    logic                          write_next;
    logic                          read_next;

    // wD bits count only while valid is high
    assign word_shift = (state == sbus_slave_pkg::WRITE_COLLECT) && valid;
    assign word_clear = hdr_accept || word_full;

    // burst continues unless last came with this word
    assign write_next = (state == sbus_slave_pkg::WRITE_COLLECT) && word_full
                     && burst && !last_seen;
    assign read_next  = (state == sbus_slave_pkg::READ_SHIFT) && done
                     && burst && !(last_seen || last);

    always_comb begin
        mem_req.rd_en = (state == sbus_slave_pkg::READ_FETCH);
        mem_req.wr_en = (state == sbus_slave_pkg::WRITE_COLLECT) && word_full;
        mem_req.addr  = addr;
        mem_req.wdata = word;
    end

    assign busy = (state != sbus_slave_pkg::IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= sbus_slave_pkg::IDLE;
            burst     <= 1'b0;
            last_seen <= 1'b0;
            load      <= 1'b0;
        end else begin
            // read data is on rdata one cycle after the fetch
            load <= (state == sbus_slave_pkg::READ_FETCH);
            case (state)
                sbus_slave_pkg::IDLE: begin
                    last_seen <= 1'b0;
                    if (hdr_accept) begin
                        burst <= header.burst;
                        state <= header.is_write ? sbus_slave_pkg::WRITE_COLLECT
                                                 : sbus_slave_pkg::READ_FETCH;
                    end
                end
                sbus_slave_pkg::WRITE_COLLECT: begin
                    if (word_full) begin
                        // a valid bit here already belongs to the next word
                        last_seen <= last && valid;
                        if (!write_next) begin
                            state <= sbus_slave_pkg::IDLE;
                        end
                    end else if (last && valid) begin
                        last_seen <= 1'b1;
                    end
                end
                sbus_slave_pkg::READ_FETCH: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                    state <= sbus_slave_pkg::READ_SHIFT;
                end
                sbus_slave_pkg::READ_SHIFT: begin
                    if (done) begin
                        last_seen <= 1'b0;
                        state     <= read_next ? sbus_slave_pkg::READ_FETCH
                                               : sbus_slave_pkg::IDLE;
                    end else if (last) begin
                        last_seen <= 1'b1;
                    end
                end
                default: state <= sbus_slave_pkg::IDLE;
            endcase
        end
    end

    // word address for the current frame
    always_ff @(posedge clk) begin
        if (hdr_accept && (state == sbus_slave_pkg::IDLE)) begin
            addr <= header.addr;
        end else if (write_next || read_next) begin
            addr <= addr + 1'b1;
        end
    end

    serial_shift_in #(
        .payload_t (sbus_frame_pkg::word_t)
    ) u_word_shift (
        .clk      (clk),
        .rstN     (rstN),
        .clear    (word_clear),
        .shift_en (word_shift),
        .bit_in   (wD),
        .payload  (word),
        .full     (word_full)
    );

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rstN)
        !(mem_req.rd_en && mem_req.wr_en));

endmodule

`default_nettype wire
